// ==== Makefile ====
TOP = tb_nts_dispatcher

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== source/nts_bram.sv ====
`timescale 1ns/100ps
`include "nts_dispatcher_config.svh"

module nts_bram (
  input  logic                          i_clk,
  input  nts_dispatcher_pkg::buf_addr_t i_addr,
  input  logic                          i_write,
  input  nts_dispatcher_pkg::mac_word_t i_data,
  output nts_dispatcher_pkg::mac_word_t o_data
);

  localparam int DEPTH = 2 ** `NTS_BUF_ADDR_WIDTH;

  nts_dispatcher_pkg::mac_word_t mem [DEPTH];

  // Write first, read data registered
  always_ff @(posedge i_clk)
  begin
    if (i_write)
    begin
      mem[i_addr] <= i_data;
      o_data      <= i_data;
    end
    else
      o_data <= mem[i_addr];
  end

endmodule

// ==== source/nts_dispatcher.sv ====
`timescale 1ns/100ps
`include "nts_dispatcher_config.svh"

module nts_dispatcher (
  input  logic                           i_clk,
  input  logic                           i_areset,

  // MAC receive
  input  nts_dispatcher_pkg::byte_mask_t i_rx_data_valid,
  input  nts_dispatcher_pkg::mac_word_t  i_rx_data,
  input  logic                           i_rx_bad_frame,
  input  logic                           i_rx_good_frame,

  // Engine dispatch
  output logic                           o_dispatch_packet_available,
  input  logic                           i_dispatch_packet_read_discard,
  output nts_dispatcher_pkg::buf_addr_t  o_dispatch_counter,
  output nts_dispatcher_pkg::byte_mask_t o_dispatch_data_valid,
  output logic                           o_dispatch_fifo_empty,
  input  logic                           i_dispatch_fifo_rd_start,
  output logic                           o_dispatch_fifo_rd_valid,
  output nts_dispatcher_pkg::mac_word_t  o_dispatch_fifo_rd_data,

  // Register bus, writes ignored
  input  logic                           i_api_cs,
  input  logic                           i_api_we,
  input  logic [`NTS_API_ADDR_WIDTH-1:0] i_api_address,
  output nts_dispatcher_pkg::api_word_t  o_api_read_data
);

  rx_word_if    rx_word ();
  stat_event_if stat_event ();

  nts_rx_ingest i_rx_ingest (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_rx_data_valid(i_rx_data_valid),
    .i_rx_data      (i_rx_data),
    .i_rx_bad_frame (i_rx_bad_frame),
    .i_rx_good_frame(i_rx_good_frame),
    .rx             (rx_word.src),
    .stat           (stat_event.from_ingest)
  );

  nts_frame_buffer i_frame_buffer (
    .i_clk             (i_clk),
    .i_areset          (i_areset),
    .rx                (rx_word.dst),
    .stat              (stat_event.from_buffer),
    .i_rd_start        (i_dispatch_fifo_rd_start),
    .i_discard         (i_dispatch_packet_read_discard),
    .o_packet_available(o_dispatch_packet_available),
    .o_last_index      (o_dispatch_counter),
    .o_last_mask       (o_dispatch_data_valid),
    .o_fifo_empty      (o_dispatch_fifo_empty),
    .o_rd_valid        (o_dispatch_fifo_rd_valid),
    .o_rd_data         (o_dispatch_fifo_rd_data)
  );

  // Observes the datapath only
  nts_dispatcher_regs i_regs (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .stat           (stat_event.to_regs),
    .i_api_cs       (i_api_cs),
    .i_api_we       (i_api_we),
    .i_api_address  (i_api_address),
    .o_api_read_data(o_api_read_data)
  );

endmodule

// ==== source/nts_dispatcher_config.svh ====
`ifndef NTS_DISPATCHER_CONFIG_SVH
`define NTS_DISPATCHER_CONFIG_SVH

// ------------------------------
// Datapath widths
// ------------------------------

`define NTS_WORD_WIDTH     64
`define NTS_MASK_WIDTH     8
// 256 words per frame buffer
`define NTS_BUF_ADDR_WIDTH 8
`define NTS_API_ADDR_WIDTH 12
`define NTS_API_DATA_WIDTH 32

// Identity, "NTS-DISP" and "0.02" in ASCII
`define NTS_CORE_NAME    64'h4e_54_53_2d_44_49_53_50
`define NTS_CORE_VERSION 32'h30_2e_30_32

// ------------------------------
// Register map
// ------------------------------

`define NTS_ADDR_NAME0          12'h000
`define NTS_ADDR_NAME1          12'h001
`define NTS_ADDR_VERSION        12'h002
`define NTS_ADDR_BYTES_RX_MSB   12'h00a
`define NTS_ADDR_BYTES_RX_LSB   12'h00b
`define NTS_ADDR_FRAMES_MSB     12'h020
`define NTS_ADDR_FRAMES_LSB     12'h021
`define NTS_ADDR_GOOD_MSB       12'h022
`define NTS_ADDR_GOOD_LSB       12'h023
`define NTS_ADDR_BAD_MSB        12'h024
`define NTS_ADDR_BAD_LSB        12'h025
`define NTS_ADDR_DISPATCHED_MSB 12'h026
`define NTS_ADDR_DISPATCHED_LSB 12'h027

`endif

// ==== source/nts_dispatcher_if.sv ====
`timescale 1ns/100ps

// MAC words after alignment, taken in the cycle they are valid
interface rx_word_if;
  logic                           word_valid;  // Mask not zero
  nts_dispatcher_pkg::mac_word_t  word;
  nts_dispatcher_pkg::byte_mask_t mask;        // Raw mask from the MAC
  logic                           sof;
  logic                           good;
  logic                           bad;

  modport src (
    output word_valid, word, mask, sof, good, bad
  );

  modport dst (
    input word_valid, word, mask, sof, good, bad
  );
endinterface

// Statistics events, one count per cycle high
interface stat_event_if;
  logic                            sof;
  logic                            good;
  logic                            bad;
  nts_dispatcher_pkg::byte_count_t byte_count;
  logic                            dispatched;

  modport from_ingest (
    output sof, good, bad, byte_count
  );

  modport from_buffer (
    output dispatched
  );

  modport to_regs (
    input sof, good, bad, byte_count, dispatched
  );
endinterface

// ==== source/nts_dispatcher_pkg.sv ====
`include "nts_dispatcher_config.svh"

package nts_dispatcher_pkg;

  typedef logic [`NTS_WORD_WIDTH-1:0]     mac_word_t;
  typedef logic [`NTS_MASK_WIDTH-1:0]     byte_mask_t;
  typedef logic [`NTS_BUF_ADDR_WIDTH-1:0] buf_addr_t;
  typedef logic [`NTS_API_DATA_WIDTH-1:0] api_word_t;
  typedef logic [63:0]                    stat_count_t;
  typedef logic [3:0]                     byte_count_t;  // 0 to 8 bytes

  // One frame buffer, receive side then readout side
  typedef enum logic [3:0] {
    EMPTY      = 4'd0,
    HAS_DATA   = 4'd1,
    RECEIVED   = 4'd2,
    OUT_READY  = 4'd3,  // Waiting for the engine
    OUT_PRIME  = 4'd4,  // RAM read register filling
    OUT_STREAM = 4'd5,
    OUT_LAST   = 4'd6,
    OUT_DONE   = 4'd7   // Held until discard
  } buf_state_t;

endpackage

// ==== source/nts_dispatcher_regs.sv ====
`timescale 1ns/100ps
`include "nts_dispatcher_config.svh"

module nts_dispatcher_regs (
  input  logic                          i_clk,
  input  logic                          i_areset,
  stat_event_if.to_regs                 stat,
  input  logic                          i_api_cs,
  input  logic                          i_api_we,
  input  logic [`NTS_API_ADDR_WIDTH-1:0] i_api_address,
  output nts_dispatcher_pkg::api_word_t o_api_read_data
);

  localparam int NUM_CNT        = 5;
  localparam int CNT_FRAMES     = 0;
  localparam int CNT_GOOD       = 1;
  localparam int CNT_BAD        = 2;
  localparam int CNT_DISPATCHED = 3;
  localparam int CNT_BYTES      = 4;

  localparam logic [63:0] CORE_NAME = `NTS_CORE_NAME;

  // Indexed by the CNT_ constants
  localparam logic [`NTS_API_ADDR_WIDTH-1:0] MSB_ADDR [NUM_CNT] = '{
    `NTS_ADDR_FRAMES_MSB,
    `NTS_ADDR_GOOD_MSB,
    `NTS_ADDR_BAD_MSB,
    `NTS_ADDR_DISPATCHED_MSB,
    `NTS_ADDR_BYTES_RX_MSB
  };
  localparam logic [`NTS_API_ADDR_WIDTH-1:0] LSB_ADDR [NUM_CNT] = '{
    `NTS_ADDR_FRAMES_LSB,
    `NTS_ADDR_GOOD_LSB,
    `NTS_ADDR_BAD_LSB,
    `NTS_ADDR_DISPATCHED_LSB,
    `NTS_ADDR_BYTES_RX_LSB
  };

  nts_dispatcher_pkg::stat_count_t cnt [NUM_CNT];
  nts_dispatcher_pkg::stat_count_t cnt_inc [NUM_CNT];
  nts_dispatcher_pkg::api_word_t   cnt_lsb [NUM_CNT];  // Latched on MSB read
  logic [NUM_CNT-1:0]              lsb_we;

  // ------------------------------
  // Statistics counters
  // ------------------------------

  always_comb
  begin
    cnt_inc[CNT_FRAMES]     = nts_dispatcher_pkg::stat_count_t'(stat.sof);
    cnt_inc[CNT_GOOD]       = nts_dispatcher_pkg::stat_count_t'(stat.good);
    cnt_inc[CNT_BAD]        = nts_dispatcher_pkg::stat_count_t'(stat.bad);
    cnt_inc[CNT_DISPATCHED] = nts_dispatcher_pkg::stat_count_t'(stat.dispatched);
    cnt_inc[CNT_BYTES]      = nts_dispatcher_pkg::stat_count_t'(stat.byte_count);
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        cnt[i]     <= '0;
        cnt_lsb[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        cnt[i] <= cnt[i] + cnt_inc[i];
        if (lsb_we[i])
          cnt_lsb[i] <= cnt[i][31:0];  // Value seen with the MSB
      end
    end
  end

  // ------------------------------
  // Read decoder
  // ------------------------------

  always_comb
  begin
    o_api_read_data = '0;
    lsb_we          = '0;
    if (i_api_cs && !i_api_we)
    begin
      case (i_api_address)
        `NTS_ADDR_NAME0:   o_api_read_data = CORE_NAME[63:32];
        `NTS_ADDR_NAME1:   o_api_read_data = CORE_NAME[31:0];
        `NTS_ADDR_VERSION: o_api_read_data = `NTS_CORE_VERSION;
        default:
        begin
          for (int i = 0; i < NUM_CNT; i++)
          begin
            if (i_api_address == MSB_ADDR[i])
            begin
              o_api_read_data = cnt[i][63:32];
              lsb_we[i]       = 1'b1;
            end
            if (i_api_address == LSB_ADDR[i])
              o_api_read_data = cnt_lsb[i];
          end
        end
      endcase
    end
  end

endmodule

// ==== source/nts_frame_buffer.sv ====
`timescale 1ns/100ps

module nts_frame_buffer (
  input  logic                           i_clk,
  input  logic                           i_areset,
  rx_word_if.dst                         rx,
  stat_event_if.from_buffer              stat,
  input  logic                           i_rd_start,
  input  logic                           i_discard,
  output logic                           o_packet_available,
  output nts_dispatcher_pkg::buf_addr_t  o_last_index,
  output nts_dispatcher_pkg::byte_mask_t o_last_mask,
  output logic                           o_fifo_empty,
  output logic                           o_rd_valid,
  output nts_dispatcher_pkg::mac_word_t  o_rd_data
);

  logic                           cur_sel;  // Buffer taking MAC words
  logic                           rd_sel;   // Buffer facing the engine
  nts_dispatcher_pkg::buf_state_t state [2];
  nts_dispatcher_pkg::buf_addr_t  count [2];
  nts_dispatcher_pkg::byte_mask_t last_mask [2];
  nts_dispatcher_pkg::buf_addr_t  rd_addr;
  nts_dispatcher_pkg::buf_addr_t  wr_addr;
  logic                           wr_en;
  logic                           cnt_full;
  nts_dispatcher_pkg::mac_word_t  ram_rd_data [2];
  logic [1:0]                     is_out;

  assign rd_sel   = ~cur_sel;
  assign cnt_full = &count[cur_sel];

  assign o_packet_available = (state[rd_sel] == nts_dispatcher_pkg::OUT_READY);
  assign o_last_index       = count[rd_sel];
  assign o_last_mask        = last_mask[rd_sel];
  assign stat.dispatched    = i_rd_start && o_packet_available;

  // ------------------------------
  // RAM write side
  // ------------------------------

  always_comb
  begin
    wr_en   = 1'b0;
    wr_addr = '0;
    if (rx.word_valid)
    begin
      case (state[cur_sel])
        nts_dispatcher_pkg::EMPTY:
          wr_en = 1'b1;
        nts_dispatcher_pkg::HAS_DATA:
        begin
          wr_en   = !cnt_full;  // Overrun words dropped
          wr_addr = count[cur_sel] + 1'b1;
        end
        // Both buffers held, word 0 of the waiting frame is rewritten
        nts_dispatcher_pkg::RECEIVED:
          wr_en = (state[rd_sel] != nts_dispatcher_pkg::EMPTY);
        default: ;
      endcase
    end
  end

  for (genvar b = 0; b < 2; b++)
  begin : g_buf
    nts_bram i_bram (
      .i_clk  (i_clk),
      .i_addr ((cur_sel == 1'(b)) ? wr_addr : rd_addr),
      .i_write(wr_en && (cur_sel == 1'(b))),
      .i_data (rx.word),
      .o_data (ram_rd_data[b])
    );

    assign is_out[b] = state[b] inside {nts_dispatcher_pkg::OUT_READY,
                                        nts_dispatcher_pkg::OUT_PRIME,
                                        nts_dispatcher_pkg::OUT_STREAM,
                                        nts_dispatcher_pkg::OUT_LAST,
                                        nts_dispatcher_pkg::OUT_DONE};
  end

  // Qualified by o_rd_valid
  always_ff @(posedge i_clk)
  begin
    o_rd_data <= ram_rd_data[rd_sel];
  end

  // ------------------------------
  // Buffer state machines
  // ------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cur_sel      <= 1'b0;
      state[0]     <= nts_dispatcher_pkg::EMPTY;
      state[1]     <= nts_dispatcher_pkg::EMPTY;
      count[0]     <= '0;
      count[1]     <= '0;
      last_mask[0] <= '0;
      last_mask[1] <= '0;
      rd_addr      <= '0;
      o_fifo_empty <= 1'b1;
      o_rd_valid   <= 1'b0;
    end
    else
    begin
      // Readout side
      if (i_discard)
      begin
        state[rd_sel] <= nts_dispatcher_pkg::EMPTY;
        o_fifo_empty  <= 1'b1;
        o_rd_valid    <= 1'b0;
      end
      else
      begin
        case (state[rd_sel])
          nts_dispatcher_pkg::OUT_READY:
          begin
            rd_addr <= '0;
            if (i_rd_start)
            begin
              state[rd_sel] <= nts_dispatcher_pkg::OUT_PRIME;
              o_fifo_empty  <= 1'b0;
            end
          end
          nts_dispatcher_pkg::OUT_PRIME,
          nts_dispatcher_pkg::OUT_STREAM:
          begin
            o_rd_valid <= (state[rd_sel] == nts_dispatcher_pkg::OUT_STREAM);
            if (rd_addr == count[rd_sel])
              state[rd_sel] <= nts_dispatcher_pkg::OUT_LAST;
            else
            begin
              state[rd_sel] <= nts_dispatcher_pkg::OUT_STREAM;
              rd_addr       <= rd_addr + 1'b1;
            end
          end
          nts_dispatcher_pkg::OUT_LAST:
          begin
            o_rd_valid    <= 1'b1;
            state[rd_sel] <= nts_dispatcher_pkg::OUT_DONE;
          end
          nts_dispatcher_pkg::OUT_DONE:
          begin
            o_rd_valid   <= 1'b0;
            o_fifo_empty <= 1'b1;
          end
          default: ;
        endcase
      end

      // Receive side
      if (rx.bad && (state[cur_sel] != nts_dispatcher_pkg::RECEIVED))
      begin
        state[cur_sel]     <= nts_dispatcher_pkg::EMPTY;
        count[cur_sel]     <= '0;
        last_mask[cur_sel] <= '0;
      end
      else
      begin
        case (state[cur_sel])
          nts_dispatcher_pkg::EMPTY:
          begin
            if (rx.word_valid)
              count[cur_sel] <= '0;
            if (rx.sof)  // Single word frame ends right away
              state[cur_sel] <= rx.good ? nts_dispatcher_pkg::RECEIVED
                                        : nts_dispatcher_pkg::HAS_DATA;
            if (rx.sof && rx.good)
              last_mask[cur_sel] <= rx.mask;
          end
          nts_dispatcher_pkg::HAS_DATA:
          begin
            if (wr_en)
              count[cur_sel] <= wr_addr;
            if (rx.good)
            begin
              last_mask[cur_sel] <= rx.mask;
              state[cur_sel]     <= nts_dispatcher_pkg::RECEIVED;
            end
          end
          nts_dispatcher_pkg::RECEIVED:
          begin
            if (state[rd_sel] == nts_dispatcher_pkg::EMPTY)
            begin
              state[cur_sel] <= nts_dispatcher_pkg::OUT_READY;  // Swap
              cur_sel        <= rd_sel;
            end
          end
          default:
            state[cur_sel] <= nts_dispatcher_pkg::EMPTY;
        endcase
      end
    end
  end

  // Only one frame faces the engine
  a_single_out: assert property (
    @(posedge i_clk) disable iff (i_areset) !(&is_out)
  );

  a_valid_not_empty: assert property (
    @(posedge i_clk) disable iff (i_areset) !(o_rd_valid && o_fifo_empty)
  );

endmodule

// ==== source/nts_rx_ingest.sv ====
`timescale 1ns/100ps

module nts_rx_ingest (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_dispatcher_pkg::byte_mask_t i_rx_data_valid,
  input  nts_dispatcher_pkg::mac_word_t  i_rx_data,
  input  logic                           i_rx_bad_frame,
  input  logic                           i_rx_good_frame,
  rx_word_if.src                         rx,
  stat_event_if.from_ingest              stat
);

  nts_dispatcher_pkg::byte_mask_t  prev_mask;
  nts_dispatcher_pkg::byte_count_t n_bytes;
  logic                            contiguous;
  logic [6:0]                      pad_bits;

  // ------------------------------
  // Byte alignment
  // ------------------------------

  always_comb
  begin
    contiguous = 1'b1;
    case (i_rx_data_valid)
      8'hff: n_bytes = 4'd8;
      8'h7f: n_bytes = 4'd7;
      8'h3f: n_bytes = 4'd6;
      8'h1f: n_bytes = 4'd5;
      8'h0f: n_bytes = 4'd4;
      8'h07: n_bytes = 4'd3;
      8'h03: n_bytes = 4'd2;
      8'h01: n_bytes = 4'd1;
      8'h00: n_bytes = 4'd0;
      default:
      begin
        n_bytes    = 4'd0;
        contiguous = 1'b0;  // Odd mask, data kept as is
      end
    endcase
  end

  // Valid bytes move to the top, zeros fill below
  assign pad_bits = {4'd8 - n_bytes, 3'b000};

  assign rx.word       = contiguous ? (i_rx_data << pad_bits) : i_rx_data;
  assign rx.word_valid = (i_rx_data_valid != 8'h00);
  assign rx.mask       = i_rx_data_valid;
  assign rx.good       = i_rx_good_frame;
  assign rx.bad        = i_rx_bad_frame;

  // ------------------------------
  // Start of frame
  // ------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_mask <= 8'hff;  // Never 00 out of reset
    else
      prev_mask <= i_rx_data_valid;
  end

  // Idle gap followed by a full word
  assign rx.sof = (prev_mask == 8'h00) && (i_rx_data_valid == 8'hff);

  assign stat.sof        = rx.sof;
  assign stat.good       = i_rx_good_frame;
  assign stat.bad        = i_rx_bad_frame;
  assign stat.byte_count = n_bytes;

  // MAC never ends a frame both ways
  a_good_bad_exclusive: assert property (
    @(posedge i_clk) disable iff (i_areset) !(i_rx_good_frame && i_rx_bad_frame)
  );

endmodule

// ==== tb.f ====
+incdir+source
source/nts_dispatcher_pkg.sv
source/nts_dispatcher_if.sv
source/nts_rx_ingest.sv
source/nts_bram.sv
source/nts_frame_buffer.sv
source/nts_dispatcher_regs.sv
source/nts_dispatcher.sv
tests/tb_nts_dispatcher.sv

// ==== tests/tb_nts_dispatcher.sv ====
`timescale 1ns/100ps
`include "nts_dispatcher_config.svh"

module tb_nts_dispatcher;

  localparam int CLK_PERIOD   = 100;
  localparam int AVAIL_LIMIT  = 200;  // Cycles
  localparam int STREAM_LIMIT = 400;
  localparam int NUM_MIX      = 24;

  localparam logic [63:0] EXP_NAME    = "NTS-DISP";
  localparam logic [31:0] EXP_VERSION = "0.02";

  logic                           i_clk;
  logic                           i_areset;
  nts_dispatcher_pkg::byte_mask_t i_rx_data_valid;
  nts_dispatcher_pkg::mac_word_t  i_rx_data;
  logic                           i_rx_bad_frame;
  logic                           i_rx_good_frame;
  logic                           o_dispatch_packet_available;
  logic                           i_dispatch_packet_read_discard;
  nts_dispatcher_pkg::buf_addr_t  o_dispatch_counter;
  nts_dispatcher_pkg::byte_mask_t o_dispatch_data_valid;
  logic                           o_dispatch_fifo_empty;
  logic                           i_dispatch_fifo_rd_start;
  logic                           o_dispatch_fifo_rd_valid;
  nts_dispatcher_pkg::mac_word_t  o_dispatch_fifo_rd_data;
  logic                           i_api_cs;
  logic                           i_api_we;
  logic [`NTS_API_ADDR_WIDTH-1:0] i_api_address;
  nts_dispatcher_pkg::api_word_t  o_api_read_data;

  integer seed;

  // ------------------------------
  // Reference model state
  // ------------------------------

  nts_dispatcher_pkg::mac_word_t  exp_words [$];  // Aligned words, frames back to back
  int                             exp_len [$];
  nts_dispatcher_pkg::byte_mask_t exp_mask [$];
  longint                         sof_count;
  longint                         good_count;
  longint                         bad_count;
  longint                         disp_count;
  longint                         byte_sum;

  nts_dispatcher i_nts_dispatcher (
    .i_clk                         (i_clk),
    .i_areset                      (i_areset),
    .i_rx_data_valid               (i_rx_data_valid),
    .i_rx_data                     (i_rx_data),
    .i_rx_bad_frame                (i_rx_bad_frame),
    .i_rx_good_frame               (i_rx_good_frame),
    .o_dispatch_packet_available   (o_dispatch_packet_available),
    .i_dispatch_packet_read_discard(i_dispatch_packet_read_discard),
    .o_dispatch_counter            (o_dispatch_counter),
    .o_dispatch_data_valid         (o_dispatch_data_valid),
    .o_dispatch_fifo_empty         (o_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_start      (i_dispatch_fifo_rd_start),
    .o_dispatch_fifo_rd_valid      (o_dispatch_fifo_rd_valid),
    .o_dispatch_fifo_rd_data       (o_dispatch_fifo_rd_data),
    .i_api_cs                      (i_api_cs),
    .i_api_we                      (i_api_we),
    .i_api_address                 (i_api_address),
    .o_api_read_data               (o_api_read_data)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ------------------------------
  // Checks and model helpers
  // ------------------------------

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic int count_bytes(input nts_dispatcher_pkg::byte_mask_t mask);
    int n;
    int i;
    n = 0;
    for (i = 0; i < 8; i++)
      if (mask[i])
        n++;
    return n;
  endfunction

  // Low n bytes end up as the top n bytes, zeros below
  function automatic nts_dispatcher_pkg::mac_word_t align_word(
    input nts_dispatcher_pkg::mac_word_t  data,
    input nts_dispatcher_pkg::byte_mask_t mask
  );
    nts_dispatcher_pkg::mac_word_t res;
    int n;
    int i;
    res = '0;
    n = count_bytes(mask);
    for (i = 0; i < n; i++)
      res[8*(8-n+i) +: 8] = data[8*i +: 8];
    return res;
  endfunction

  function automatic int random_len();
    return 1 + int'($unsigned($random(seed)) % 40);
  endfunction

  task automatic drive_rx(input nts_dispatcher_pkg::byte_mask_t mask,
                          input nts_dispatcher_pkg::mac_word_t data,
                          input logic good,
                          input logic bad);
    @(negedge i_clk);
    i_rx_data_valid = mask;
    i_rx_data       = data;
    i_rx_good_frame = good;
    i_rx_bad_frame  = bad;
  endtask

  // held: both buffers occupied, every word lands on word 0 of the waiting frame
  task automatic send_frame(input int len, input logic good_end, input logic held);
    nts_dispatcher_pkg::mac_word_t  words [$];
    nts_dispatcher_pkg::mac_word_t  data;
    nts_dispatcher_pkg::byte_mask_t mask;
    nts_dispatcher_pkg::byte_mask_t last_mask;
    int                             gap;
    int                             n_last;
    int                             i;
    gap       = 1 + int'($unsigned($random(seed)) % 4);
    n_last    = (len == 1) ? 8 : 1 + int'($unsigned($random(seed)) % 8);
    last_mask = 8'hff >> (8 - n_last);
    repeat (gap) drive_rx('0, '0, 1'b0, 1'b0);  // Idle gap arms SOF
    for (i = 0; i < len; i++)
    begin
      mask = (i == len - 1) ? last_mask : 8'hff;
      data = {$random(seed), $random(seed)};
      drive_rx(mask, data, (i == len - 1) && good_end, (i == len - 1) && !good_end);
      words.push_back(align_word(data, mask));
      byte_sum += longint'(count_bytes(mask));
    end
    drive_rx('0, '0, 1'b0, 1'b0);
    sof_count++;
    if (good_end)
      good_count++;
    else
      bad_count++;
    if (held)
      exp_words[exp_len[0]] = words[len - 1];
    else if (good_end)
    begin
      for (i = 0; i < len; i++)
        exp_words.push_back(words[i]);
      exp_len.push_back(len);
      exp_mask.push_back(last_mask);
    end
  endtask

  // ------------------------------
  // Dispatch side
  // ------------------------------

  task automatic wait_available();
    int cycles;
    for (cycles = 0; cycles < AVAIL_LIMIT && !o_dispatch_packet_available; cycles++)
      @(negedge i_clk);
    if (!o_dispatch_packet_available)
    begin
      $display("Timeout: no frame became available for dispatch");
      abort_run();
    end
  endtask

  task automatic expect_no_frame(input int cycles, input string what);
    int i;
    for (i = 0; i < cycles; i++)
    begin
      @(negedge i_clk);
      check_equal(64'(o_dispatch_packet_available), 64'd0, what);
    end
  endtask

  task automatic start_readout();
    @(negedge i_clk);
    i_dispatch_fifo_rd_start = 1'b1;
    disp_count++;
    @(negedge i_clk);
    i_dispatch_fifo_rd_start = 1'b0;
  endtask

  task automatic discard_frame();
    int i;
    @(negedge i_clk);
    i_dispatch_packet_read_discard = 1'b1;
    @(negedge i_clk);
    i_dispatch_packet_read_discard = 1'b0;
    check_equal(64'(o_dispatch_fifo_rd_valid), 64'd0, "rd_valid after discard");
    check_equal(64'(o_dispatch_fifo_empty), 64'd1, "empty after discard");
    for (i = 0; i < exp_len[0]; i++)
      exp_words.delete(0);
    exp_len.delete(0);
    exp_mask.delete(0);
  endtask

  // Front frame of the model, streamed in full and then released
  task automatic check_frame();
    int len;
    int idx;
    int cycles;
    len = exp_len[0];
    wait_available();
    check_equal(64'(o_dispatch_counter), 64'(len - 1), "last word index");
    check_equal(64'(o_dispatch_data_valid), 64'(exp_mask[0]), "last word mask");
    start_readout();
    idx = 0;
    for (cycles = 0; cycles < STREAM_LIMIT && !o_dispatch_fifo_empty; cycles++)
    begin
      @(negedge i_clk);
      if (o_dispatch_fifo_rd_valid)
      begin
        if (idx >= len)
          check_equal(64'(idx + 1), 64'(len), "words in stream");
        else
          check_equal(o_dispatch_fifo_rd_data, exp_words[idx], "stream word");
        idx++;
      end
    end
    if (!o_dispatch_fifo_empty)
    begin
      $display("Timeout: the dispatch stream never ended");
      abort_run();
    end
    check_equal(64'(idx), 64'(len), "words in stream");
    discard_frame();
  endtask

  task automatic early_discard();
    int idx;
    int cycles;
    wait_available();
    start_readout();
    idx = 0;
    for (cycles = 0; cycles < STREAM_LIMIT && idx < 3; cycles++)
    begin
      @(negedge i_clk);
      if (o_dispatch_fifo_rd_valid)
      begin
        check_equal(o_dispatch_fifo_rd_data, exp_words[idx], "word before discard");
        idx++;
      end
    end
    if (idx < 3)
    begin
      $display("Timeout: the stream did not deliver its first words");
      abort_run();
    end
    discard_frame();
  endtask

  // ------------------------------
  // Register bus
  // ------------------------------

  task automatic read_reg(input logic [`NTS_API_ADDR_WIDTH-1:0] addr,
                          output nts_dispatcher_pkg::api_word_t data);
    @(negedge i_clk);
    i_api_cs      = 1'b1;
    i_api_we      = 1'b0;
    i_api_address = addr;
    #(CLK_PERIOD / 4);  // Combinational read data settles
    data = o_api_read_data;
  endtask

  task automatic bus_idle();
    @(negedge i_clk);
    i_api_cs      = 1'b0;
    i_api_we      = 1'b0;
    i_api_address = '0;
  endtask

  task automatic check_counter(input logic [`NTS_API_ADDR_WIDTH-1:0] msb,
                               input logic [`NTS_API_ADDR_WIDTH-1:0] lsb,
                               input longint expected,
                               input string what);
    nts_dispatcher_pkg::api_word_t hi;
    nts_dispatcher_pkg::api_word_t lo;
    read_reg(msb, hi);
    read_reg(lsb, lo);  // Lower half latched by the MSB read
    bus_idle();
    check_equal({hi, lo}, expected, what);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial
  begin
    nts_dispatcher_pkg::api_word_t rdata;
    int                            n;

    seed                           = 32'he92d13fb;
    i_areset                       = 1'b1;
    i_rx_data_valid                = '0;
    i_rx_data                      = '0;
    i_rx_bad_frame                 = 1'b0;
    i_rx_good_frame                = 1'b0;
    i_dispatch_packet_read_discard = 1'b0;
    i_dispatch_fifo_rd_start       = 1'b0;
    i_api_cs                       = 1'b0;
    i_api_we                       = 1'b0;
    i_api_address                  = '0;
    sof_count                      = 0;
    good_count                     = 0;
    bad_count                      = 0;
    disp_count                     = 0;
    byte_sum                       = 0;

    repeat (5) @(negedge i_clk);
    i_areset = 1'b0;
    @(negedge i_clk);
    check_equal(64'(o_dispatch_packet_available), 64'd0, "available after reset");
    check_equal(64'(o_dispatch_fifo_rd_valid), 64'd0, "rd_valid after reset");
    check_equal(64'(o_dispatch_fifo_empty), 64'd1, "empty after reset");
    check_counter(`NTS_ADDR_BYTES_RX_MSB, `NTS_ADDR_BYTES_RX_LSB, 0, "bytes after reset");
    check_counter(`NTS_ADDR_FRAMES_MSB, `NTS_ADDR_FRAMES_LSB, 0, "frames after reset");
    check_counter(`NTS_ADDR_GOOD_MSB, `NTS_ADDR_GOOD_LSB, 0, "good after reset");
    check_counter(`NTS_ADDR_BAD_MSB, `NTS_ADDR_BAD_LSB, 0, "bad after reset");
    check_counter(`NTS_ADDR_DISPATCHED_MSB, `NTS_ADDR_DISPATCHED_LSB, 0,
                  "dispatched after reset");

    // Identity registers
    read_reg(`NTS_ADDR_NAME0, rdata);
    check_equal(64'(rdata), 64'(EXP_NAME[63:32]), "name, upper half");
    read_reg(`NTS_ADDR_NAME1, rdata);
    check_equal(64'(rdata), 64'(EXP_NAME[31:0]), "name, lower half");
    read_reg(`NTS_ADDR_VERSION, rdata);
    check_equal(64'(rdata), 64'(EXP_VERSION), "version");
    read_reg(12'h003, rdata);
    check_equal(64'(rdata), 64'd0, "unknown address 0x003");
    read_reg(12'h3ff, rdata);
    check_equal(64'(rdata), 64'd0, "unknown address 0x3ff");
    bus_idle();

    // Random mix of good and bad frames
    for (n = 0; n < NUM_MIX; n++)
    begin
      if (($unsigned($random(seed)) % 4) == 0)
      begin
        send_frame(random_len(), 1'b0, 1'b0);
        expect_no_frame(10, "bad frame offered for dispatch");
      end
      else
      begin
        send_frame(random_len(), 1'b1, 1'b0);
        check_frame();
      end
    end
    send_frame(random_len(), 1'b0, 1'b0);
    expect_no_frame(10, "bad frame offered for dispatch");
    send_frame(random_len(), 1'b1, 1'b0);
    check_frame();

    // Ping-pong, third frame hits two held buffers
    send_frame(random_len(), 1'b1, 1'b0);
    wait_available();
    send_frame(random_len(), 1'b1, 1'b0);
    send_frame(random_len(), 1'b1, 1'b1);
    check_frame();
    check_frame();
    expect_no_frame(30, "dropped frame offered for dispatch");

    // Discard in mid stream, then reuse
    send_frame(10 + int'($unsigned($random(seed)) % 31), 1'b1, 1'b0);
    early_discard();
    send_frame(random_len(), 1'b1, 1'b0);
    check_frame();

    check_counter(`NTS_ADDR_FRAMES_MSB, `NTS_ADDR_FRAMES_LSB, sof_count, "frames started");
    check_counter(`NTS_ADDR_GOOD_MSB, `NTS_ADDR_GOOD_LSB, good_count, "good frames");
    check_counter(`NTS_ADDR_BAD_MSB, `NTS_ADDR_BAD_LSB, bad_count, "bad frames");
    check_counter(`NTS_ADDR_DISPATCHED_MSB, `NTS_ADDR_DISPATCHED_LSB, disp_count,
                  "frames dispatched");
    check_counter(`NTS_ADDR_BYTES_RX_MSB, `NTS_ADDR_BYTES_RX_LSB, byte_sum, "bytes received");

    $display("TEST PASSED");
    $finish;
  end

endmodule
